/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_cpu_core
RTL_TOP ?= cpu_core
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
RTL_FILES ?= logic/cpu_isa_pkg.sv logic/cpu_ctrl_pkg.sv logic/decoder.sv \
	logic/muxs.sv logic/reg_file.sv logic/alu.sv logic/data_mem.sv logic/cpu_core.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* logic/alu.sv */
`timescale 1ns/1ps

module alu
	import cpu_ctrl_pkg::*;
#(
	parameter int data_width = 32
) (
	input  alu_op_e               op,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	output logic [data_width-1:0] result,
	output logic                  equal
);

	localparam int shamt_width = $clog2(data_width);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_sll: result = a << b[shamt_width-1:0];
			default: result = '0;
		endcase
	end

	// branch compare, whatever op is.
	assign equal = (a == b);

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int data_width = cpu_isa_pkg::data_width,
	parameter int dmem_depth = 256
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                inst_valid,
	input  inst_u               inst,
	output logic                inst_ready,
	output logic [pc_width-1:0] fetch_pc,
	output logic                retire_valid,
	output retire_t             retire
);

	ctrl_t ctrl;
	logic [4:0] rd, rs1, rs2;
	logic [data_width-1:0] ra_data, rb_data, rt_data;
	logic [data_width-1:0] src2, alu_result, mem_rdata, wb_data;
	logic alu_equal;
	pc_sel_e select_pc;
	wb_sel_e wb_select;
	logic [pc_width-1:0] pc, next_pc;
	logic load_pending;
	logic [4:0] load_rd;
	logic [pc_width-1:0] load_next_pc;
	logic accept, reg_we;

	assign inst_ready = !load_pending; // one stall cycle per load.
	assign fetch_pc = pc;
	assign accept = inst_valid && inst_ready;

	// branch taken only on equal.
	assign select_pc = ctrl.is_branch ? (alu_equal ? pc_br14 : pc_seq) : ctrl.pc_sel;
	assign wb_select = load_pending ? wb_mem : ctrl.wb_sel;
	assign reg_we = load_pending || (accept && ctrl.reg_write && !ctrl.mem_read);

	decoder u_decoder (.inst(inst), .ctrl(ctrl), .rd(rd), .rs1(rs1), .rs2(rs2));

	reg_file #(.data_width(data_width)) u_reg_file (
		.clk(clk), .reset(reset), .we(reg_we),
		.waddr(load_pending ? load_rd : rd), .wdata(wb_data),
		.raddr_a(rs1), .raddr_b(rs2), .raddr_c(rd),
		.rdata_a(ra_data), .rdata_b(rb_data), .rdata_c(rt_data)
	);

	muxs #(.data_width(data_width)) u_muxs (
		.current_pc(pc), .sub_op_sv(inst.reg_form.sv),
		.reg_rb_data(rb_data), .reg_rt_data(rt_data),
		.mem_read_data(mem_rdata), .alu_output(alu_result),
		.imm_5bit(inst.reg_form.rb), .imm_14bit(inst.imm_form.imm15[13:0]),
		.imm_15bit(inst.imm_form.imm15),
		.imm_20bit({inst.imm_form.ra, inst.imm_form.imm15}),
		.imm_24bit({inst.imm_form.rt[3:0], inst.imm_form.ra, inst.imm_form.imm15}),
		.select_pc(select_pc), .alu_src2_select(ctrl.src2_sel),
		.imm_extend_select(ctrl.imm_ext), .write_reg_select(wb_select),
		.next_pc(next_pc), .output_imm_reg_mux(src2), .write_reg_data(wb_data)
	);

	alu #(.data_width(data_width)) u_alu (
		.op(ctrl.alu_op), .a(ra_data), .b(src2), .result(alu_result), .equal(alu_equal)
	);

	data_mem #(.data_width(data_width), .depth(dmem_depth)) u_data_mem (
		.clk(clk), .rd_en(accept && ctrl.mem_read),
		.wr_en(accept && ctrl.mem_write && !reset),
		.addr(alu_result), .wdata(rt_data), .rdata(mem_rdata)
	);

	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			load_pending <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			retire_valid <= 1'b0;
			if (load_pending) begin
				load_pending <= 1'b0;
				pc <= load_next_pc;
				retire_valid <= 1'b1;
			end else if (accept) begin
				if (ctrl.mem_read) begin
					load_pending <= 1'b1; // retire next cycle.
				end else begin
					pc <= next_pc;
					retire_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_pending) begin
			retire <= '{rd_write: 1'b1, rd: load_rd, value: wb_data, next_pc: load_next_pc};
		end else if (accept && !ctrl.mem_read) begin
			retire <= '{rd_write: ctrl.reg_write, rd: rd, value: wb_data, next_pc: next_pc};
		end
		if (accept && ctrl.mem_read) begin
			load_rd <= rd;
			load_next_pc <= next_pc;
		end
	end

endmodule

/* logic/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	import cpu_isa_pkg::*;

	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		pc_seq  = 2'b00,
		pc_br14 = 2'b01,
		pc_j24  = 2'b10
	} pc_sel_e;

	typedef enum logic [1:0] {
		imm_ze5  = 2'b00,
		imm_se15 = 2'b01,
		imm_ze15 = 2'b10,
		imm_se20 = 2'b11
	} imm_ext_e;

	typedef enum logic [2:0] {
		src2_rb      = 3'b000,
		src2_imm     = 3'b001,
		src2_off15_w = 3'b010,
		src2_rb_sv   = 3'b011,
		src2_rt      = 3'b100
	} src2_sel_e;

	typedef enum logic [1:0] {
		wb_alu  = 2'b00,
		wb_opnd = 2'b01,
		wb_mem  = 2'b10
	} wb_sel_e;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_sll = 3'd5
	} alu_op_e;

	// ------------------------------------------------------------
	typedef struct packed {
		pc_sel_e   pc_sel;
		imm_ext_e  imm_ext;
		src2_sel_e src2_sel;
		wb_sel_e   wb_sel;
		alu_op_e   alu_op;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		logic      is_branch;
	} ctrl_t;

	typedef struct packed {
		logic                  rd_write;
		logic [4:0]            rd;
		logic [data_width-1:0] value;
		logic [pc_width-1:0]   next_pc;
	} retire_t;

endpackage

/* logic/cpu_isa_pkg.sv */
package cpu_isa_pkg;

	parameter int data_width = 32;
	parameter int pc_width = 10;

	// ------------------------------------------------------------
	// major opcodes, word bits 30:25.
	typedef enum logic [5:0] {
		op_lwi  = 6'h02,
		op_swi  = 6'h0a,
		op_alu  = 6'h20,
		op_movi = 6'h22,
		op_j    = 6'h24,
		op_beq  = 6'h26,
		op_addi = 6'h28,
		op_ori  = 6'h2c
	} opcode_e;

	// register-format sub-opcodes, word bits 4:0.
	typedef enum logic [4:0] {
		sub_add    = 5'h00,
		sub_sub    = 5'h01,
		sub_and    = 5'h02,
		sub_xor    = 5'h03,
		sub_or     = 5'h04,
		sub_slli   = 5'h08,
		sub_add_sv = 5'h10 // rb shifted left by sv.
	} alu_sub_e;

	// ------------------------------------------------------------
	// imm14, imm20 and imm24 are sliced from the low bits.
	typedef struct packed {
		logic        len16; // zero for the 32-bit forms.
		opcode_e     opcode;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm15;
	} imm_form_t;

	typedef struct packed {
		logic       len16;
		opcode_e    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb; // also imm5 for slli.
		logic [1:0] sv;
		logic [2:0] rsvd;
		alu_sub_e   sub;
	} reg_form_t;

	typedef union packed {
		imm_form_t imm_form;
		reg_form_t reg_form;
	} inst_u;

endpackage

/* logic/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
	parameter int data_width = 32,
	parameter int depth = 256
) (
	input  logic                  clk,
	input  logic                  rd_en,
	input  logic                  wr_en,
	input  logic [data_width-1:0] addr,
	input  logic [data_width-1:0] wdata,
	output logic [data_width-1:0] rdata
);

	localparam int addr_width = $clog2(depth);

	logic [data_width-1:0] mem [depth];
	logic [addr_width-1:0] word_addr;

	assign word_addr = addr[addr_width+1:2]; // byte offset dropped.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[word_addr] <= wdata;
		end
		if (rd_en) begin
			rdata <= mem[word_addr];
		end
	end

endmodule

/* logic/decoder.sv */
`timescale 1ns/1ps

module decoder
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input  inst_u      inst,
	output ctrl_t      ctrl,
	output logic [4:0] rd,
	output logic [4:0] rs1,
	output logic [4:0] rs2
);

	localparam ctrl_t ctrl_nop = '{
		pc_sel:    pc_seq,
		imm_ext:   imm_se15,
		src2_sel:  src2_rb,
		wb_sel:    wb_alu,
		alu_op:    alu_add,
		reg_write: 1'b0,
		mem_read:  1'b0,
		mem_write: 1'b0,
		is_branch: 1'b0
	};

	always_comb begin
		ctrl = ctrl_nop;
		rd = inst.imm_form.rt;
		rs1 = inst.imm_form.ra;
		rs2 = inst.reg_form.rb;
		case (inst.imm_form.opcode)
			op_alu: begin
				ctrl.reg_write = 1'b1;
				case (inst.reg_form.sub)
					sub_add: ctrl.alu_op = alu_add;
					sub_sub: ctrl.alu_op = alu_sub;
					sub_and: ctrl.alu_op = alu_and;
					sub_or:  ctrl.alu_op = alu_or;
					sub_xor: ctrl.alu_op = alu_xor;
					sub_slli: begin
						ctrl.alu_op = alu_sll;
						ctrl.src2_sel = src2_imm;
						ctrl.imm_ext = imm_ze5; // shift amount in rb field.
					end
					sub_add_sv: ctrl.src2_sel = src2_rb_sv;
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			op_addi: begin
				ctrl.src2_sel = src2_imm;
				ctrl.reg_write = 1'b1;
			end
			op_ori: begin
				ctrl.src2_sel = src2_imm;
				ctrl.imm_ext = imm_ze15;
				ctrl.alu_op = alu_or;
				ctrl.reg_write = 1'b1;
			end
			op_movi: begin
				ctrl.src2_sel = src2_imm;
				ctrl.imm_ext = imm_se20;
				ctrl.wb_sel = wb_opnd; // immediate straight to rt.
				ctrl.reg_write = 1'b1;
			end
			op_lwi: begin
				ctrl.src2_sel = src2_off15_w;
				ctrl.wb_sel = wb_mem;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
			end
			op_swi: begin
				ctrl.src2_sel = src2_off15_w;
				ctrl.mem_write = 1'b1;
				rs2 = inst.imm_form.rt;
			end
			op_beq: begin
				ctrl.src2_sel = src2_rt; // ra compared with rt.
				ctrl.pc_sel = pc_br14;
				ctrl.is_branch = 1'b1;
				rs2 = inst.imm_form.rt;
			end
			op_j: ctrl.pc_sel = pc_j24;
			default: ctrl = ctrl_nop;
		endcase
	end

endmodule

/* logic/muxs.sv */
`timescale 1ns/1ps

module muxs
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
#(
	parameter int data_width = 32
) (
	input  logic [pc_width-1:0]   current_pc,
	input  logic [1:0]            sub_op_sv,
	input  logic [data_width-1:0] reg_rb_data,
	input  logic [data_width-1:0] reg_rt_data,
	input  logic [data_width-1:0] mem_read_data,
	input  logic [data_width-1:0] alu_output,
	input  logic [4:0]            imm_5bit,
	input  logic [13:0]           imm_14bit,
	input  logic [14:0]           imm_15bit,
	input  logic [19:0]           imm_20bit,
	input  logic [23:0]           imm_24bit,
	input  pc_sel_e               select_pc,
	input  src2_sel_e             alu_src2_select,
	input  imm_ext_e              imm_extend_select,
	input  wb_sel_e               write_reg_select,
	output logic [pc_width-1:0]   next_pc,
	output logic [data_width-1:0] output_imm_reg_mux,
	output logic [data_width-1:0] write_reg_data
);

	logic [data_width-1:0] imm;

	// ------------------------------------------------------------
	// offset is sign bit and low byte, halfword scaled.
	always_comb begin
		case (select_pc)
			pc_seq:  next_pc = current_pc + pc_width'(4);
			pc_br14: next_pc = current_pc + pc_width'({imm_14bit[13], imm_14bit[7:0], 1'b0});
			pc_j24:  next_pc = current_pc + pc_width'({imm_24bit[23], imm_24bit[7:0], 1'b0});
			default: next_pc = '0;
		endcase
	end

	always_comb begin
		case (imm_extend_select)
			imm_ze5:  imm = {{(data_width-5){1'b0}}, imm_5bit};
			imm_se15: imm = {{(data_width-15){imm_15bit[14]}}, imm_15bit};
			imm_ze15: imm = {{(data_width-15){1'b0}}, imm_15bit};
			imm_se20: imm = {{(data_width-20){imm_20bit[19]}}, imm_20bit};
			default:  imm = '0;
		endcase
	end

	// ------------------------------------------------------------
	always_comb begin
		case (alu_src2_select)
			src2_rb:      output_imm_reg_mux = reg_rb_data;
			src2_imm:     output_imm_reg_mux = imm;
			src2_off15_w: begin
				output_imm_reg_mux = {{(data_width-17){imm_15bit[14]}}, imm_15bit, 2'b00};
			end
			src2_rb_sv:   output_imm_reg_mux = reg_rb_data << sub_op_sv;
			src2_rt:      output_imm_reg_mux = reg_rt_data;
			default:      output_imm_reg_mux = '0;
		endcase
	end

	always_comb begin
		case (write_reg_select)
			wb_alu:  write_reg_data = alu_output;
			wb_opnd: write_reg_data = output_imm_reg_mux;
			wb_mem:  write_reg_data = mem_read_data;
			default: write_reg_data = '0;
		endcase
	end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
	parameter int data_width = 32
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  we,
	input  logic [4:0]            waddr,
	input  logic [data_width-1:0] wdata,
	input  logic [4:0]            raddr_a,
	input  logic [4:0]            raddr_b,
	input  logic [4:0]            raddr_c,
	output logic [data_width-1:0] rdata_a,
	output logic [data_width-1:0] rdata_b,
	output logic [data_width-1:0] rdata_c
);

	logic [data_width-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != 5'd0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 reads as zero.
	assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
	assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];
	assign rdata_c = (raddr_c == 5'd0) ? '0 : regs[raddr_c];

endmodule

/* project.f */
logic/cpu_isa_pkg.sv
logic/cpu_ctrl_pkg.sv
logic/decoder.sv
logic/muxs.sv
logic/reg_file.sv
logic/alu.sv
logic/data_mem.sv
logic/cpu_core.sv
sim/cpu_core_checker.sv
sim/tb_cpu_core.sv

/* sim/cpu_core_checker.sv */
`timescale 1ns/1ps

module cpu_core_checker
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
(
	input logic                clk,
	input logic                reset,
	input logic                inst_valid,
	input inst_u               inst,
	input logic                inst_ready,
	input logic [pc_width-1:0] fetch_pc,
	input logic                retire_valid,
	input logic                mem_read,
	input pc_sel_e             select_pc
);

	// ------------------------------------------------------------
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		inst_valid && !inst_ready |=> $stable(inst))
		else $error("inst changed while stalled");

	reset_quiet: assert property (@(posedge clk) reset |=> !retire_valid)
		else $error("retire_valid high after reset");

	load_stall: assert property (@(posedge clk) disable iff (reset)
		inst_valid && inst_ready && mem_read |=> !inst_ready ##1 inst_ready)
		else $error("load stall is not one cycle");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		fetch_pc[1:0] == 2'b00 || $past(select_pc != pc_seq))
		else $error("fetch_pc not word aligned");

endmodule

bind cpu_core cpu_core_checker u_checker (
	.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
	.inst_ready(inst_ready), .fetch_pc(fetch_pc), .retire_valid(retire_valid),
	.mem_read(ctrl.mem_read), .select_pc(select_pc)
);

/* sim/tb_cpu_core.sv */
`timescale 1ns/1ps

module tb_cpu_core
	import cpu_isa_pkg::*;
	import cpu_ctrl_pkg::*;
;

	localparam int clk_period = 8;
	localparam int first_run = 300;
	localparam int total_run = 520;
	localparam int body_start = 24; // movi and swi setup before it.

	logic clk;
	logic reset;
	logic inst_valid;
	inst_u inst;
	logic inst_ready;
	logic [pc_width-1:0] fetch_pc;
	logic retire_valid;
	retire_t retire;

	inst_u prog [256];
	logic [data_width-1:0] model_regs [32];
	logic [data_width-1:0] model_mem [256];
	logic [pc_width-1:0] model_pc;
	retire_t expect_q [$];
	int seed = 32'h15a9_9bf0;
	int accepted = 0;
	logic drive_en = 1'b0;

	cpu_core #(.data_width(data_width), .dmem_depth(256)) UUT (
		.clk(clk), .reset(reset), .inst_valid(inst_valid), .inst(inst),
		.inst_ready(inst_ready), .fetch_pc(fetch_pc),
		.retire_valid(retire_valid), .retire(retire)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------------------------------------
	function automatic inst_u enc_imm(opcode_e op, int rt, int ra, logic [14:0] imm);
		inst_u w;
		w.imm_form = '{len16: 1'b0, opcode: op, rt: rt[4:0], ra: ra[4:0], imm15: imm};
		return w;
	endfunction

	function automatic inst_u enc_reg(int rt, int ra, int rb, int sv, alu_sub_e sub);
		inst_u w;
		w.reg_form = '{len16: 1'b0, opcode: op_alu, rt: rt[4:0], ra: ra[4:0],
			rb: rb[4:0], sv: sv[1:0], rsvd: 3'b000, sub: sub};
		return w;
	endfunction

	function automatic inst_u random_inst();
		alu_sub_e subs [7] = '{sub_add, sub_sub, sub_and, sub_or, sub_xor, sub_slli, sub_add_sv};
		logic [31:0] r;
		int kind;
		r = $random(seed);
		kind = {$random(seed)} % 10;
		case (kind)
			0, 1, 2: return enc_reg(r[3:0], r[7:4], r[12:8], r[14:13], subs[{$random(seed)} % 7]);
			3: return enc_imm(op_addi, r[19:16], r[23:20], r[14:0]);
			4: return enc_imm(op_ori, r[19:16], r[23:20], r[14:0]);
			5: return enc_imm(op_movi, r[19:16], r[24:20], r[14:0]);
			6: return enc_imm(op_lwi, r[19:16], 0, 15'(r[3:0]));
			7: return enc_imm(op_swi, r[19:16], 0, 15'(r[3:0]));
			8: return enc_imm(op_beq, r[18:16], r[22:20], {r[14:1], 1'b0}); // small regs, often equal.
			default: return enc_imm(op_j, r[20:16], r[25:21], {r[14:1], 1'b0});
		endcase
	endfunction

	// reference model of one instruction.
	function automatic retire_t step_model(inst_u w);
		retire_t res;
		logic [data_width-1:0] a, b, addr;
		logic [pc_width-1:0] off;
		a = model_regs[w.imm_form.ra];
		b = model_regs[w.reg_form.rb];
		addr = a + {{15{w.imm_form.imm15[14]}}, w.imm_form.imm15, 2'b00};
		res = '{rd_write: 1'b1, rd: w.imm_form.rt, value: '0, next_pc: model_pc + 10'd4};
		case (w.imm_form.opcode)
			op_alu: begin
				case (w.reg_form.sub)
					sub_add: res.value = a + b;
					sub_sub: res.value = a - b;
					sub_and: res.value = a & b;
					sub_or: res.value = a | b;
					sub_xor: res.value = a ^ b;
					sub_slli: res.value = a << w.reg_form.rb;
					default: res.value = a + (b << w.reg_form.sv);
				endcase
			end
			op_addi: res.value = a + {{17{w.imm_form.imm15[14]}}, w.imm_form.imm15};
			op_ori: res.value = a | {17'd0, w.imm_form.imm15};
			op_movi: res.value = {{12{w[19]}}, w[19:0]};
			op_lwi: res.value = model_mem[addr[9:2]];
			op_swi: begin
				model_mem[addr[9:2]] = model_regs[w.imm_form.rt];
				res.rd_write = 1'b0;
			end
			op_beq: begin
				res.rd_write = 1'b0;
				off = {w[13], w[7:0], 1'b0};
				if (a == model_regs[w.imm_form.rt]) res.next_pc = model_pc + off;
			end
			default: begin
				res.rd_write = 1'b0;
				off = {w[23], w[7:0], 1'b0};
				res.next_pc = model_pc + off;
			end
		endcase
		if (res.rd_write && res.rd != 5'd0) model_regs[res.rd] = res.value;
		model_pc = res.next_pc;
		return res;
	endfunction

	// ------------------------------------------------------------
	task automatic compare_retire(string name, retire_t exp, retire_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "retire mismatch");
		end
	endtask

	task automatic compare_pc(string name, logic [pc_width-1:0] exp, logic [pc_width-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "fetch pc mismatch");
		end
	endtask

	task automatic compare_word(string name, logic [data_width-1:0] exp,
		logic [data_width-1:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Some tests failed");
			$fatal(1, "register mismatch");
		end
	endtask

	// drive just after the edge.
	always @(posedge clk) begin
		#1;
		inst_valid = drive_en && ({$random(seed)} % 4 != 0);
		inst = prog[model_pc[9:2]]; // next expected instruction, held through a stall.
	end

	// compare process, sampled mid-cycle.
	always @(negedge clk) begin
		retire_t exp, act;
		if (!reset) begin
			if (retire_valid) begin
				if (expect_q.size() == 0) begin
					$display("a retire came out with no instruction outstanding");
					$display("Some tests failed");
					$fatal(1, "unexpected retire");
				end
				exp = expect_q.pop_front();
				act = retire;
				if (!exp.rd_write) exp.value = '0; // value unused without write.
				if (!act.rd_write) act.value = '0;
				compare_retire("retire", exp, act);
			end
			if (inst_valid && inst_ready) begin
				compare_pc("fetch_pc", model_pc, fetch_pc);
				expect_q.push_back(step_model(inst));
				accepted++;
			end
		end
	end

	initial begin
		#((total_run * 20 + 100) * clk_period);
		$display("watchdog expired before the program finished");
		$display("Some tests failed");
		$fatal(1, "timeout");
	end

	task automatic drain();
		do @(negedge clk); while (expect_q.size() != 0 || inst_valid);
	endtask

	// ------------------------------------------------------------
	initial begin
		logic [31:0] r;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			r[19] = (i % 2 == 0); // both signs of imm20.
			prog[i] = enc_imm(op_movi, i + 1, r[19:15], r[14:0]);
		end
		for (int k = 0; k < 16; k++) prog[8 + k] = enc_imm(op_swi, 1 + k % 8, 0, 15'(k));
		for (int i = body_start; i < 256; i++) prog[i] = random_inst();
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		for (int i = 0; i < 256; i++) model_mem[i] = '0;
		model_pc = '0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;
		drive_en = 1'b1;
		wait (accepted >= first_run);
		drive_en = 1'b0;
		drain();
		// reset in the middle of the program.
		@(posedge clk);
		#1 reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		compare_pc("pc after reset", '0, fetch_pc);
		for (int i = 0; i < 32; i++) compare_word("reg after reset", '0, UUT.u_reg_file.regs[i]);
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		model_pc = '0;
		@(posedge clk);
		#1 reset = 1'b0;
		drive_en = 1'b1;
		wait (accepted >= total_run);
		drive_en = 1'b0;
		drain();
		$display("All tests passed");
		$finish;
	end

endmodule
